/* source/chiplet_defs.svh */
`ifndef CHIPLET_DEFS_SVH
`define CHIPLET_DEFS_SVH

// Router geometry
`define SW_PORTS 4
`define SW_VCS 2
`define PORT_BITS 2

// Flit buffering
`define FIFO_DEPTH 8
`define FIFO_PTR_BITS 3
`define FIFO_CNT_BITS 4

// Flit and header fields
`define NODE_BITS 4
`define PKT_ID_BITS 4
`define LEN_BITS 7
`define SHORT_LEN_BITS 4
`define FMT_BITS 4
`define PAYLOAD_BITS 32
`define ROUTE_ENTRIES (1 << `NODE_BITS)

`endif

/* source/chiplet_pkg.sv */
`default_nettype none

`include "chiplet_defs.svh"

package chiplet_pkg;

    typedef logic [`NODE_BITS-1:0] node_id_t;
    typedef logic [`PKT_ID_BITS-1:0] pkt_id_t;
    typedef logic [`PORT_BITS-1:0] port_sel_t;

    typedef enum logic [`FMT_BITS-1:0] {
        FMT_SHORT_READ  = 4'd0,
        FMT_SHORT_WRITE = 4'd1,
        FMT_LONG_READ   = 4'd2,
        FMT_LONG_WRITE  = 4'd3,
        FMT_MSG         = 4'd4
    } fmt_t;

    typedef struct packed {
        fmt_t                                                     fmt;
        node_id_t                                                 dest;
        logic [`PAYLOAD_BITS-`FMT_BITS-`NODE_BITS-`LEN_BITS-1:0] reserved;
        logic [`LEN_BITS-1:0]                                     length;
    } header_t;

    // Same 32 bits, header flit or data flit
    typedef union packed {
        header_t                  hdr;
        logic [`PAYLOAD_BITS-1:0] data;
    } payload_u;

    typedef struct packed {
        logic     vc;
        pkt_id_t  id;
        node_id_t req;     // Source node
        payload_u payload;
    } flit_t;

    typedef struct packed {
        logic      we;
        node_id_t  addr;
        port_sel_t port;
    } route_cfg_t;

endpackage

`default_nettype wire

/* source/flit_fifos.sv */
`default_nettype none

`include "chiplet_defs.svh"

module flit_fifos (
    input  logic                                          clk,
    input  logic                                          n_rst,
    input  chiplet_pkg::flit_t [`SW_PORTS-1:0]            in,
    input  logic [`SW_PORTS-1:0]                          data_ready_in,
    input  logic [`SW_PORTS-1:0][`SW_VCS-1:0]             rd_en,
    output chiplet_pkg::flit_t [`SW_PORTS-1:0][`SW_VCS-1:0] head,
    output logic [`SW_PORTS-1:0][`SW_VCS-1:0]             empty,
    output logic [`SW_PORTS-1:0][`SW_VCS-1:0]             buffer_available
);

    for (genvar p = 0; p < `SW_PORTS; p++) begin : g_port
        for (genvar v = 0; v < `SW_VCS; v++) begin : g_vc
            chiplet_pkg::flit_t mem [`FIFO_DEPTH];
            logic [`FIFO_PTR_BITS-1:0] wr_ptr;
            logic [`FIFO_PTR_BITS-1:0] rd_ptr;
            logic [`FIFO_CNT_BITS-1:0] count;
            logic                      full;
            logic                      wr_en;
            logic                      rd_ok;

            assign full  = count == `FIFO_CNT_BITS'(`FIFO_DEPTH);
            assign wr_en = data_ready_in[p] && (in[p].vc == 1'(v)) && !full; // Drop when full
            assign rd_ok = rd_en[p][v] && (count != '0);

            always_ff @(posedge clk, negedge n_rst) begin
                if (!n_rst) begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                    count  <= '0;
                end else begin
                    if (wr_en)
                        wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
                    if (rd_ok)
                        rd_ptr <= rd_ptr + 1'b1;
                    case ({wr_en, rd_ok})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;
                    endcase
                end
            end

            always_ff @(posedge clk) begin
                if (wr_en)
                    mem[wr_ptr] <= in[p];
            end

            // First word fall through
            assign head[p][v]             = mem[rd_ptr];
            assign empty[p][v]            = count == '0;
            assign buffer_available[p][v] = !full;
        end
    end

endmodule

`default_nettype wire

/* source/route_compute.sv */
`default_nettype none

`include "chiplet_defs.svh"

module route_compute (
    input  logic                                         clk,
    input  logic                                         n_rst,
    input  chiplet_pkg::route_cfg_t                      route_cfg,
    input  chiplet_pkg::flit_t [`SW_PORTS-1:0]           head_flit,
    output chiplet_pkg::port_sel_t [`SW_PORTS-1:0]       out_port,
    output logic [`SW_PORTS-1:0][`LEN_BITS-1:0]          data_len
);

    chiplet_pkg::port_sel_t route_table [`ROUTE_ENTRIES];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `ROUTE_ENTRIES; i++)
                route_table[i] <= '0;
        end else if (route_cfg.we) begin
            route_table[route_cfg.addr] <= route_cfg.port;
        end
    end

    // Only meaningful while a header sits at the head
    always_comb begin
        chiplet_pkg::header_t hdr;
        for (int p = 0; p < `SW_PORTS; p++) begin
            hdr         = head_flit[p].payload.hdr;
            out_port[p] = route_table[hdr.dest];
            case (hdr.fmt)
                chiplet_pkg::FMT_SHORT_READ,
                chiplet_pkg::FMT_SHORT_WRITE: begin
                    data_len[p] = {{(`LEN_BITS-`SHORT_LEN_BITS){1'b0}},
                                   hdr.length[`SHORT_LEN_BITS-1:0]};
                end
                chiplet_pkg::FMT_LONG_READ,
                chiplet_pkg::FMT_LONG_WRITE: begin
                    data_len[p] = hdr.length;
                end
                default: begin
                    data_len[p] = '0; // Message, header only
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/switch_control.sv */
`default_nettype none

`include "chiplet_defs.svh"

module switch_control (
    input  logic                                              clk,
    input  logic                                              n_rst,
    input  chiplet_pkg::flit_t [`SW_PORTS-1:0][`SW_VCS-1:0]   head,
    input  logic [`SW_PORTS-1:0][`SW_VCS-1:0]                 empty,
    input  chiplet_pkg::port_sel_t [`SW_PORTS-1:0]            out_port,
    input  logic [`SW_PORTS-1:0][`LEN_BITS-1:0]               data_len,
    input  logic [`SW_PORTS-1:0][`SW_PORTS-1:0]               grant,
    output logic [`SW_PORTS-1:0][`SW_VCS-1:0]                 rd_en,
    output chiplet_pkg::flit_t [`SW_PORTS-1:0]                head_flit,
    output logic [`SW_PORTS-1:0]                              req_valid,
    output chiplet_pkg::port_sel_t [`SW_PORTS-1:0]            req_port,
    output logic [`SW_PORTS-1:0]                              pkt_release,
    output logic [`SW_PORTS-1:0]                              read_fire
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_SEND
    } state_t;

    state_t [`SW_PORTS-1:0]                state;
    logic [`SW_PORTS-1:0]                  vc_sel;
    logic [`SW_PORTS-1:0]                  at_hdr;     // Next read is the header
    logic [`SW_PORTS-1:0][`LEN_BITS-1:0]   remaining;
    logic [`SW_PORTS-1:0]                  sel_empty;
    logic [`SW_PORTS-1:0]                  other_empty;
    logic [`SW_PORTS-1:0]                  granted;

    always_comb begin
        rd_en = '0;
        for (int p = 0; p < `SW_PORTS; p++) begin
            sel_empty[p]   = empty[p][vc_sel[p]];
            other_empty[p] = empty[p][!vc_sel[p]];
            head_flit[p]   = head[p][vc_sel[p]];

            req_valid[p] = (state[p] == ST_IDLE || state[p] == ST_REQ) && !sel_empty[p];
            req_port[p]  = out_port[p];
            granted[p]   = req_valid[p] && grant[out_port[p]][p];

            // Stall on an empty FIFO, the output sees a bubble
            read_fire[p]         = (state[p] == ST_SEND) && !sel_empty[p];
            rd_en[p][vc_sel[p]]  = read_fire[p];

            pkt_release[p] = read_fire[p] &&
                             (at_hdr[p] ? data_len[p] == '0 : remaining[p] == `LEN_BITS'(1));
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                state[p]     <= ST_IDLE;
                vc_sel[p]    <= 1'b0;
                at_hdr[p]    <= 1'b0;
                remaining[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                case (state[p])
                    ST_IDLE: begin
                        if (granted[p]) begin
                            state[p]  <= ST_SEND;
                            at_hdr[p] <= 1'b1;
                        end else if (req_valid[p]) begin
                            state[p] <= ST_REQ;
                        end else if (!other_empty[p]) begin
                            vc_sel[p] <= !vc_sel[p]; // Nothing here, try the other VC
                        end
                    end
                    ST_REQ: begin
                        if (granted[p]) begin
                            state[p]  <= ST_SEND;
                            at_hdr[p] <= 1'b1;
                        end
                    end
                    default: begin
                        if (read_fire[p]) begin
                            if (at_hdr[p]) begin
                                remaining[p] <= data_len[p];
                                at_hdr[p]    <= 1'b0;
                            end else begin
                                remaining[p] <= remaining[p] - 1'b1;
                            end
                        end
                        if (pkt_release[p]) begin
                            state[p] <= ST_IDLE;
                            if (!other_empty[p])
                                vc_sel[p] <= !vc_sel[p];
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/switch_allocator.sv */
`default_nettype none

`include "chiplet_defs.svh"

module switch_allocator (
    input  logic                                       clk,
    input  logic                                       n_rst,
    input  logic [`SW_PORTS-1:0]                       req_valid,
    input  chiplet_pkg::port_sel_t [`SW_PORTS-1:0]     req_port,
    input  logic [`SW_PORTS-1:0]                       pkt_release,
    output logic [`SW_PORTS-1:0][`SW_PORTS-1:0]        grant
);

    logic [`SW_PORTS-1:0]                    busy;
    chiplet_pkg::port_sel_t [`SW_PORTS-1:0]  owner;
    chiplet_pkg::port_sel_t [`SW_PORTS-1:0]  ptr;     // Highest priority input
    logic [`SW_PORTS-1:0][`SW_PORTS-1:0]     reqs;
    logic [`SW_PORTS-1:0]                    found;
    chiplet_pkg::port_sel_t [`SW_PORTS-1:0]  winner;

    always_comb begin
        chiplet_pkg::port_sel_t idx;
        for (int o = 0; o < `SW_PORTS; o++) begin
            for (int i = 0; i < `SW_PORTS; i++)
                reqs[o][i] = req_valid[i] && (req_port[i] == chiplet_pkg::port_sel_t'(o));

            found[o]  = 1'b0;
            winner[o] = ptr[o];
            for (int k = 0; k < `SW_PORTS; k++) begin
                idx = ptr[o] + chiplet_pkg::port_sel_t'(k);
                if (!found[o] && reqs[o][idx]) begin
                    found[o]  = 1'b1;
                    winner[o] = idx;
                end
            end

            // Owner keeps the output until its release
            grant[o] = '0;
            if (busy[o])
                grant[o][owner[o]] = 1'b1;
            else if (found[o])
                grant[o][winner[o]] = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            busy  <= '0;
            owner <= '0;
            ptr   <= '0;
        end else begin
            for (int o = 0; o < `SW_PORTS; o++) begin
                if (!busy[o] && found[o]) begin
                    busy[o]  <= 1'b1;
                    owner[o] <= winner[o];
                    ptr[o]   <= winner[o] + 1'b1;
                end else if (busy[o] && pkt_release[owner[o]]) begin
                    busy[o] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/crossbar.sv */
`default_nettype none

`include "chiplet_defs.svh"

module crossbar (
    input  logic                                   clk,
    input  logic                                   n_rst,
    input  chiplet_pkg::flit_t [`SW_PORTS-1:0]     in_flits,
    input  logic [`SW_PORTS-1:0]                   read_fire,
    input  logic [`SW_PORTS-1:0][`SW_PORTS-1:0]    grant,
    output chiplet_pkg::flit_t [`SW_PORTS-1:0]     out,
    output logic [`SW_PORTS-1:0]                   data_ready_out
);

    chiplet_pkg::flit_t [`SW_PORTS-1:0]   flit_q;   // Flits popped last edge
    logic [`SW_PORTS-1:0]                 fire_q;
    logic [`SW_PORTS-1:0][`SW_PORTS-1:0]  grant_q;
    chiplet_pkg::flit_t [`SW_PORTS-1:0]   nxt_flit;
    logic [`SW_PORTS-1:0]                 nxt_valid;

    always_comb begin
        for (int o = 0; o < `SW_PORTS; o++) begin
            nxt_flit[o]  = '0;
            nxt_valid[o] = 1'b0;
            for (int i = 0; i < `SW_PORTS; i++) begin
                if (grant_q[o][i]) begin
                    nxt_flit[o]  = flit_q[i];
                    nxt_valid[o] = fire_q[i];
                end
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            fire_q         <= '0;
            grant_q        <= '0;
            data_ready_out <= '0;
        end else begin
            fire_q         <= read_fire;
            grant_q        <= grant;
            data_ready_out <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        flit_q <= in_flits;
        out    <= nxt_flit;
    end

endmodule

`default_nettype wire

/* source/switch.sv */
`default_nettype none

`include "chiplet_defs.svh"

module switch (
    input  logic                                        clk,
    input  logic                                        n_rst,
    input  chiplet_pkg::flit_t [`SW_PORTS-1:0]          in,
    input  logic [`SW_PORTS-1:0]                        data_ready_in,
    input  chiplet_pkg::route_cfg_t                     route_cfg,
    output chiplet_pkg::flit_t [`SW_PORTS-1:0]          out,
    output logic [`SW_PORTS-1:0]                        data_ready_out,
    output logic [`SW_PORTS-1:0][`SW_VCS-1:0]           buffer_available
);

    chiplet_pkg::flit_t [`SW_PORTS-1:0][`SW_VCS-1:0]  head;
    logic [`SW_PORTS-1:0][`SW_VCS-1:0]                empty;
    logic [`SW_PORTS-1:0][`SW_VCS-1:0]                rd_en;
    chiplet_pkg::flit_t [`SW_PORTS-1:0]               head_flit;  // Selected VC per input
    chiplet_pkg::port_sel_t [`SW_PORTS-1:0]           out_port;
    logic [`SW_PORTS-1:0][`LEN_BITS-1:0]              data_len;
    logic [`SW_PORTS-1:0]                             req_valid;
    chiplet_pkg::port_sel_t [`SW_PORTS-1:0]           req_port;
    logic [`SW_PORTS-1:0]                             pkt_release;
    logic [`SW_PORTS-1:0]                             read_fire;
    logic [`SW_PORTS-1:0][`SW_PORTS-1:0]              grant;      // [output][input]

    flit_fifos fifos_i (
        .clk              (clk),
        .n_rst            (n_rst),
        .in               (in),
        .data_ready_in    (data_ready_in),
        .rd_en            (rd_en),
        .head             (head),
        .empty            (empty),
        .buffer_available (buffer_available)
    );

    route_compute route_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .route_cfg (route_cfg),
        .head_flit (head_flit),
        .out_port  (out_port),
        .data_len  (data_len)
    );

    switch_control control_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .head        (head),
        .empty       (empty),
        .out_port    (out_port),
        .data_len    (data_len),
        .grant       (grant),
        .rd_en       (rd_en),
        .head_flit   (head_flit),
        .req_valid   (req_valid),
        .req_port    (req_port),
        .pkt_release (pkt_release),
        .read_fire   (read_fire)
    );

    switch_allocator alloc_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .req_valid   (req_valid),
        .req_port    (req_port),
        .pkt_release (pkt_release),
        .grant       (grant)
    );

    // The flit being read is the selected head
    crossbar xbar_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .in_flits       (head_flit),
        .read_fire      (read_fire),
        .grant          (grant),
        .out            (out),
        .data_ready_out (data_ready_out)
    );

endmodule

`default_nettype wire

/* tests/switch_checker.sv */
`default_nettype none

`include "chiplet_defs.svh"

module switch_checker (
    input logic                               clk,
    input chiplet_pkg::flit_t [`SW_PORTS-1:0] out,
    input logic [`SW_PORTS-1:0]               data_ready_out
);

    timeunit 1ns;
    timeprecision 100ps;

    // Expected flits, indexed by input port and VC
    chiplet_pkg::flit_t     exp_q [`SW_PORTS*`SW_VCS][$];
    int                     len_q [`SW_PORTS*`SW_VCS][$];
    chiplet_pkg::port_sel_t route_mirror [`ROUTE_ENTRIES];

    logic [`SW_PORTS-1:0]   in_pkt = '0;
    int                     remaining [`SW_PORTS];
    int                     cur_q [`SW_PORTS];      // Source queue of the packet in flight
    chiplet_pkg::flit_t     cur_hdr [`SW_PORTS];
    int                     error_count = 0;
    int                     flit_count = 0;

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic set_route(input chiplet_pkg::node_id_t addr, input chiplet_pkg::port_sel_t port);
        route_mirror[addr] = port;
    endtask

    task automatic expect_header(input int p, input int v, input chiplet_pkg::flit_t f,
                                 input int n_data);
        exp_q[p*`SW_VCS+v].push_back(f);
        len_q[p*`SW_VCS+v].push_back(n_data);
    endtask

    task automatic expect_data(input int p, input int v, input chiplet_pkg::flit_t f);
        exp_q[p*`SW_VCS+v].push_back(f);
    endtask

    function automatic int pending();
        int total;
        total = 0;
        for (int i = 0; i < `SW_PORTS*`SW_VCS; i++)
            total += exp_q[i].size();
        return total;
    endfunction

    task automatic check_flit(input int o, input chiplet_pkg::flit_t f);
        chiplet_pkg::flit_t exp;
        int idx;
        flit_count++;
        idx = in_pkt[o] ? cur_q[o] : f.req * `SW_VCS + f.vc;
        if ((!in_pkt[o] && f.req >= `SW_PORTS) || exp_q[idx].size() == 0) begin
            $display("Output %0d sent a flit at %0t that no input was expected to send", o, $time);
            error_count++;
            in_pkt[o] = 1'b0;
            return;
        end
        exp = exp_q[idx].pop_front();
        if (!in_pkt[o]) begin
            remaining[o] = len_q[idx].pop_front();
            compare(f, exp, $sformatf("header on output %0d", o));
            compare(o, route_mirror[exp.payload.hdr.dest], "output port for header dest");
            cur_q[o]   = idx;
            cur_hdr[o] = exp;
        end else begin
            // Packet must not be interleaved with another one
            compare(f.id, cur_hdr[o].id, $sformatf("packet id on output %0d", o));
            compare(f.req, cur_hdr[o].req, $sformatf("source on output %0d", o));
            compare(f, exp, $sformatf("data flit on output %0d", o));
            remaining[o]--;
        end
        in_pkt[o] = remaining[o] != 0;
    endtask

    // Outputs change on the rising edge
    always @(negedge clk) begin
        for (int o = 0; o < `SW_PORTS; o++) begin
            if (data_ready_out[o])
                check_flit(o, out[o]);
        end
    end

endmodule

`default_nettype wire

/* tests/switch_tb.sv */
`default_nettype none

`include "chiplet_defs.svh"

module switch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PKTS_PER_PORT = 10;
    localparam int WAIT_LIMIT    = 5000;
    localparam int DRAIN_LIMIT   = 20000;
    localparam logic [`SW_PORTS*`SW_VCS-1:0] ALL_AVAIL = '1;

    logic                                clk;
    logic                                n_rst;
    chiplet_pkg::flit_t [`SW_PORTS-1:0]  in_flits;
    logic [`SW_PORTS-1:0]                data_ready_in;
    chiplet_pkg::route_cfg_t             route_cfg;
    chiplet_pkg::flit_t [`SW_PORTS-1:0]  out_flits;
    logic [`SW_PORTS-1:0]                data_ready_out;
    logic [`SW_PORTS-1:0][`SW_VCS-1:0]   buffer_available;

    chiplet_pkg::flit_t stim_q [`SW_PORTS][$];
    bit                 gap_q [`SW_PORTS][$];    // Idle cycle before the flit
    int                 timeouts = 0;

    switch switch_i (
        .clk              (clk),
        .n_rst            (n_rst),
        .in               (in_flits),
        .data_ready_in    (data_ready_in),
        .route_cfg        (route_cfg),
        .out              (out_flits),
        .data_ready_out   (data_ready_out),
        .buffer_available (buffer_available)
    );

    switch_checker checker_i (
        .clk            (clk),
        .out            (out_flits),
        .data_ready_out (data_ready_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int count_data_flits(input chiplet_pkg::header_t hdr);
        case (hdr.fmt)
            chiplet_pkg::FMT_SHORT_READ,
            chiplet_pkg::FMT_SHORT_WRITE: return int'(hdr.length[3:0]);
            chiplet_pkg::FMT_LONG_READ,
            chiplet_pkg::FMT_LONG_WRITE:  return int'(hdr.length);
            default:                      return 0;  // Message
        endcase
    endfunction

    task automatic build_packet(input int p);
        chiplet_pkg::flit_t f;
        int n_data;
        f.vc              = 1'($urandom_range(1, 0));
        f.id              = chiplet_pkg::pkt_id_t'($urandom);
        f.req             = chiplet_pkg::node_id_t'(p);
        f.payload.data    = $urandom;    // Random dest, length and reserved bits
        f.payload.hdr.fmt = chiplet_pkg::fmt_t'($urandom_range(4, 0));
        n_data = count_data_flits(f.payload.hdr);
        stim_q[p].push_back(f);
        gap_q[p].push_back($urandom_range(3, 0) == 0);
        checker_i.expect_header(p, f.vc, f, n_data);
        for (int i = 0; i < n_data; i++) begin
            f.payload.data = $urandom;
            stim_q[p].push_back(f);
            gap_q[p].push_back($urandom_range(3, 0) == 0);
            checker_i.expect_data(p, f.vc, f);
        end
    endtask

    task automatic send_port(input int p);
        chiplet_pkg::flit_t f;
        int waited;
        while (stim_q[p].size() > 0) begin
            f = stim_q[p].pop_front();
            data_ready_in[p] = 1'b0;
            if (gap_q[p].pop_front()) begin
                in_flits[p] = ~f;   // Junk without the strobe
                @(negedge clk);
            end
            waited = 0;
            while (!buffer_available[p][f.vc] && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!buffer_available[p][f.vc]) begin
                $display("Timeout: input %0d VC %0d never had buffer space", p, f.vc);
                timeouts++;
                return;
            end
            in_flits[p]      = f;
            data_ready_in[p] = 1'b1;
            @(negedge clk);
        end
        data_ready_in[p] = 1'b0;
    endtask

    initial begin
        int waited;
        void'($urandom(5));
        n_rst         = 1'b0;
        in_flits      = '0;
        data_ready_in = '0;
        route_cfg     = '0;
        repeat (5) begin
            @(negedge clk);
            checker_i.compare(data_ready_out, '0, "data_ready_out during reset");
        end
        n_rst = 1'b1;
        checker_i.compare(buffer_available, ALL_AVAIL, "buffer_available after reset");

        // Random route table, mirrored in the checker
        for (int a = 0; a < `ROUTE_ENTRIES; a++) begin
            route_cfg.we   = 1'b1;
            route_cfg.addr = chiplet_pkg::node_id_t'(a);
            route_cfg.port = chiplet_pkg::port_sel_t'($urandom);
            checker_i.set_route(route_cfg.addr, route_cfg.port);
            @(negedge clk);
        end
        route_cfg.we = 1'b0;

        for (int p = 0; p < `SW_PORTS; p++)
            for (int k = 0; k < PKTS_PER_PORT; k++)
                build_packet(p);

        fork
            send_port(0);
            send_port(1);
            send_port(2);
            send_port(3);
        join

        waited = 0;
        while (checker_i.pending() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (checker_i.pending() != 0) begin
            $display("Timeout: %0d expected flits never left the router", checker_i.pending());
            timeouts++;
        end
        repeat (10) @(negedge clk);   // Quiet period, catches stray flits
        checker_i.compare(buffer_available, ALL_AVAIL, "buffer_available after drain");

        $display("Summary: %0d flits checked, %0d errors, %0d timeouts",
                 checker_i.flit_count, checker_i.error_count, timeouts);
        if (checker_i.error_count == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+source
source/chiplet_pkg.sv
source/flit_fifos.sv
source/route_compute.sv
source/switch_control.sv
source/switch_allocator.sv
source/crossbar.sv
source/switch.sv
tests/switch_checker.sv
tests/switch_tb.sv
